//--- design/cfg_shadow_pkg.sv
package cfg_shadow_pkg;

  // Sideband addresses that the shadow block decodes out of the sixteen
  // the hard IP cycles through
  localparam logic [3:0] cfg_addr_dev_ctl = 4'h0;
  localparam logic [3:0] cfg_addr_command = 4'h3;
  localparam logic [3:0] cfg_addr_bus_dev = 4'hF;

  // Field widths fixed by the PCIe header layout
  localparam int unsigned addr_w    = 32;
  localparam int unsigned req_len_w = 13;
  localparam int unsigned len_dw_w  = 10;
  localparam int unsigned tag_w     = 5;
  localparam int unsigned code_w    = 3;

  // Max read request in bytes is this base shifted left by the 3-bit code
  localparam int unsigned max_rd_bytes_base = 128;
  // A memory read must never cross this boundary
  localparam int unsigned page_bytes = 4096;

  // Device control layout on address 0x0
  // The command word on address 0x3 lands in the low bits, bus master enable is bit 2
  typedef struct packed {
    logic [16:0]       rsvd_hi;
    logic [code_w-1:0] max_rd_code;
    logic [3:0]        rsvd_mid;
    logic [code_w-1:0] max_payload_code;
    logic [4:0]        low;
  } dev_ctl_view_t;

  // Bus and device number layout on address 0xF
  typedef struct packed {
    logic [18:0] rsvd;
    logic [7:0]  bus;
    logic [4:0]  dev;
  } bus_dev_view_t;

  // One tl_cfg_ctl word, read one way or the other depending on the address
  typedef union packed {
    dev_ctl_view_t dev_ctl;
    bus_dev_view_t bus_dev;
  } cfg_ctl_word_u;

  // Requester ID as bus:device.function, function is always 0 here
  typedef struct packed {
    logic [7:0] bus;
    logic [4:0] dev;
    logic [2:0] func;
  } req_id_t;

  // One memory read header, a length of 0 stands for 1024 dwords
  typedef struct packed {
    logic [addr_w-1:0]   addr;
    logic [len_dw_w-1:0] len_dw;
    req_id_t             req_id;
    logic [tag_w-1:0]    tag;
  } rd_hdr_t;

endpackage

//--- design/cfg_shadow_if.sv
`timescale 1ns/1ps

// Decoded shadow settings, written by the register block and read by
// the read request splitter
interface cfg_shadow_if;
  import cfg_shadow_pkg::*;

  // Requester ID, held at zero until every group has been captured
  req_id_t           req_id;
  // Bus and device number have been captured at least once
  logic              id_valid;
  // Raw max read request and max payload codes from device control
  logic [code_w-1:0] max_rd_code;
  logic [code_w-1:0] max_payload_code;
  // Bus master enable from the command word
  logic              bus_master_en;
  // All three groups seen since reset
  logic              settings_valid;

  // The register block owns every field
  modport regs (
    output req_id,
    output id_valid,
    output max_rd_code,
    output max_payload_code,
    output bus_master_en,
    output settings_valid
  );

  // The splitter only looks at them
  modport user (
    input req_id,
    input id_valid,
    input max_rd_code,
    input max_payload_code,
    input bus_master_en,
    input settings_valid
  );

endinterface

//--- design/cfg_sideband_sampler.sv
`timescale 1ns/1ps

// The hard IP presents each tl_cfg address for eight cycles. Its data is
// only guaranteed settled in the middle of that window, so the capture
// point is derived from the address toggle rather than taken at once
module cfg_sideband_sampler (
  input  logic        clk,
  input  logic        reset,
  input  logic [3:0]  tl_cfg_add,
  input  logic [31:0] tl_cfg_ctl,
  output logic        cap_valid,
  output logic [3:0]  cap_addr,
  output logic [31:0] cap_data
);

  // Two flops on address bit 0, since consecutive addresses always differ there
  logic add0_q1;
  logic add0_q2;
  // Change flag and its delay line towards mid-window
  logic add_chg;
  logic add_chg_d1;
  logic mid_window;

  // The pulse pipeline lands cap_valid five cycles after bit 0 toggles
  always_ff @(posedge clk) begin
    if (reset) begin
      add0_q1    <= 1'b0;
      add0_q2    <= 1'b0;
      add_chg    <= 1'b0;
      add_chg_d1 <= 1'b0;
      mid_window <= 1'b0;
      cap_valid  <= 1'b0;
    end else begin
      add0_q1    <= tl_cfg_add[0];
      add0_q2    <= add0_q1;
      // Comparing the two stages marks the first cycle after a toggle
      add_chg    <= add0_q1 != add0_q2;
      add_chg_d1 <= add_chg;
      mid_window <= add_chg_d1;
      cap_valid  <= mid_window;
    end
  end

  // Address and data are taken together on the mid-window pulse
  // They then hold until the next window's capture
  always_ff @(posedge clk) begin
    if (mid_window) begin
      cap_addr <= tl_cfg_add;
      cap_data <= tl_cfg_ctl;
    end
  end

  // Every window is eight cycles long, so two captures can never touch.
  // A back-to-back pulse means the sideband is toggling faster than specified
  a_cap_single: assert property (@(posedge clk) disable iff (reset)
    cap_valid |=> !cap_valid);

endmodule

//--- design/cfg_shadow_regs.sv
`timescale 1ns/1ps

// Keeps the decoded copy of the three sideband words this design needs.
// Everything else on the sweep is captured by the sampler and ignored here
module cfg_shadow_regs (
  input  logic        clk,
  input  logic        reset,
  input  logic        cap_valid,
  input  logic [3:0]  cap_addr,
  input  logic [31:0] cap_data,
  cfg_shadow_if.regs  shadow,
  output logic [15:0] my_id,
  output logic        my_id_valid
);
  import cfg_shadow_pkg::*;

  // The same captured word, decoded through whichever view the address selects
  cfg_ctl_word_u     ctl;

  // Device control group
  logic [code_w-1:0] max_rd_q;
  logic [code_w-1:0] max_payload_q;
  logic              dev_ctl_seen;

  // Command group
  logic              bme_q;
  logic              command_seen;

  // Bus and device group
  logic [7:0]        bus_q;
  logic [4:0]        dev_q;
  logic              bus_dev_seen;

  logic              all_seen;
  req_id_t           id_word;
  req_id_t           id_gated;

  assign ctl = cap_data;

  // Each group updates the cycle after its capture pulse and stays
  // put until the next sweep brings that address round again
  always_ff @(posedge clk) begin
    if (reset) begin
      max_rd_q      <= '0;
      max_payload_q <= '0;
      dev_ctl_seen  <= 1'b0;
      bme_q         <= 1'b0;
      command_seen  <= 1'b0;
      bus_q         <= '0;
      dev_q         <= '0;
      bus_dev_seen  <= 1'b0;
    end else if (cap_valid) begin
      case (cap_addr)
        cfg_addr_dev_ctl: begin
          max_rd_q      <= ctl.dev_ctl.max_rd_code;
          max_payload_q <= ctl.dev_ctl.max_payload_code;
          dev_ctl_seen  <= 1'b1;
        end
        cfg_addr_command: begin
          // Bus master enable sits in bit 2 of the command word
          bme_q        <= ctl.dev_ctl.low[2];
          command_seen <= 1'b1;
        end
        cfg_addr_bus_dev: begin
          bus_q        <= ctl.bus_dev.bus;
          dev_q        <= ctl.bus_dev.dev;
          bus_dev_seen <= 1'b1;
        end
        default: begin
          // Other addresses carry nothing the splitter uses
        end
      endcase
    end
  end

  // Only after a full sweep is the whole set trustworthy
  assign all_seen = dev_ctl_seen & command_seen & bus_dev_seen;

  // Function number is always zero for this single-function endpoint
  assign id_word  = '{bus: bus_q, dev: dev_q, func: 3'd0};
  assign id_gated = all_seen ? id_word : '0;

  assign shadow.req_id           = id_gated;
  assign shadow.id_valid         = bus_dev_seen;
  assign shadow.max_rd_code      = max_rd_q;
  assign shadow.max_payload_code = max_payload_q;
  assign shadow.bus_master_en    = bme_q;
  assign shadow.settings_valid   = all_seen;

  // Status copy for the rest of the system, e.g. b3:00.0 on the host side
  assign my_id       = id_gated;
  assign my_id_valid = all_seen;

endmodule

//--- design/rd_req_splitter.sv
`timescale 1ns/1ps

// Turns one client read into a run of memory read headers.
// Each chunk is bounded by max read request size and by the next 4 KB page
module rd_req_splitter (
  input  logic                                   clk,
  input  logic                                   reset,
  input  logic                                   rd_req,
  input  logic [cfg_shadow_pkg::addr_w-1:0]      rd_addr,
  input  logic [cfg_shadow_pkg::req_len_w-1:0]   rd_len,
  input  logic                                   hdr_ready,
  cfg_shadow_if.user                             shadow,
  output logic                                   rd_ack,
  output logic                                   rd_err,
  output logic                                   hdr_valid,
  output cfg_shadow_pkg::rd_hdr_t                hdr
);
  import cfg_shadow_pkg::*;

  // Smallest of remaining bytes, max read request and distance to the page end
  function automatic logic [req_len_w-1:0] chunk_bytes(
    input logic [addr_w-1:0]    addr,
    input logic [req_len_w-1:0] rem,
    input logic [code_w-1:0]    code
  );
    logic [15:0]          max_rd;
    logic [req_len_w-1:0] to_page;
    logic [req_len_w-1:0] chunk;
    // Code 7 gives 16 KB, so the shift needs headroom above 13 bits
    max_rd  = 16'(max_rd_bytes_base) << code;
    to_page = req_len_w'(page_bytes) - {1'b0, addr[11:0]};
    chunk   = rem;
    if ({3'b000, chunk} > max_rd) begin
      chunk = max_rd[req_len_w-1:0];
    end
    if (chunk > to_page) begin
      chunk = to_page;
    end
    return chunk;
  endfunction

  // The walk pointer always points at the chunk after the one on the bus
  logic [addr_w-1:0]    walk_addr;
  logic [req_len_w-1:0] walk_rem;
  // Settings frozen at request time so a mid-walk update cannot split a request oddly
  logic [code_w-1:0]    rd_code_q;
  req_id_t              id_q;

  // Header fields on the bus
  logic [addr_w-1:0]    hdr_addr_q;
  logic [len_dw_w-1:0]  hdr_len_q;
  logic [tag_w-1:0]     tag_cnt;

  logic                 idle;
  logic                 start;
  logic                 refuse;
  logic                 accept;
  logic [req_len_w-1:0] first_chunk;
  logic [req_len_w-1:0] next_chunk;
  logic [req_len_w-1:0] hdr_bytes;

  // With no header pending and no ack held the splitter is free
  assign idle   = !hdr_valid && !rd_ack;
  assign start  = idle && rd_req;
  assign accept = hdr_valid && hdr_ready;

  // Refuse when the function may not master, or the request is not a
  // dword-aligned read of 4 to 4096 bytes
  assign refuse = !shadow.settings_valid || !shadow.id_valid || !shadow.bus_master_en ||
                  (rd_len == '0) || (rd_len > req_len_w'(page_bytes)) ||
                  (rd_len[1:0] != 2'b00) || (rd_addr[1:0] != 2'b00);

  // First chunk straight from the client, later ones from the walk registers
  assign first_chunk = chunk_bytes(rd_addr, rd_len, shadow.max_rd_code);
  assign next_chunk  = chunk_bytes(walk_addr, walk_rem, rd_code_q);

  // Handshake and tag control
  always_ff @(posedge clk) begin
    if (reset) begin
      hdr_valid <= 1'b0;
      rd_ack    <= 1'b0;
      rd_err    <= 1'b0;
      tag_cnt   <= '0;
    end else if (start) begin
      if (refuse) begin
        rd_ack <= 1'b1;
        rd_err <= 1'b1;
      end else begin
        hdr_valid <= 1'b1;
      end
    end else if (accept) begin
      // Tag wraps at 32 by width
      tag_cnt <= tag_cnt + 1'b1;
      if (walk_rem == '0) begin
        hdr_valid <= 1'b0;
        rd_ack    <= 1'b1;
      end
    end else if (rd_ack && !rd_req) begin
      // Four-phase return to zero
      rd_ack <= 1'b0;
      rd_err <= 1'b0;
    end
  end

  // Header and walk data
  always_ff @(posedge clk) begin
    if (start) begin
      hdr_addr_q <= rd_addr;
      // 4096 bytes leaves the dword field at zero, the 1024-dword encoding
      hdr_len_q  <= first_chunk[11:2];
      walk_addr  <= rd_addr + addr_w'(first_chunk);
      walk_rem   <= rd_len - first_chunk;
      rd_code_q  <= shadow.max_rd_code;
      id_q       <= shadow.req_id;
    end else if (accept && walk_rem != '0) begin
      hdr_addr_q <= walk_addr;
      hdr_len_q  <= next_chunk[11:2];
      walk_addr  <= walk_addr + addr_w'(next_chunk);
      walk_rem   <= walk_rem - next_chunk;
    end
  end

  // Tag comes from the counter, which only moves on acceptance
  assign hdr = '{addr: hdr_addr_q, len_dw: hdr_len_q, req_id: id_q, tag: tag_cnt};

  // Byte length of the header on the bus, zero length meaning a full 4 KB
  assign hdr_bytes = {hdr.len_dw == '0, hdr.len_dw, 2'b00};

  // Held header must not change under back-pressure, tag included
  a_hdr_stable: assert property (@(posedge clk) disable iff (reset)
    hdr_valid && !hdr_ready |=> hdr_valid && $stable(hdr));

  // A read that crosses a 4 KB page is malformed on the link
  a_no_page_cross: assert property (@(posedge clk) disable iff (reset)
    hdr_valid |-> ({1'b0, hdr.addr[11:0]} + hdr_bytes) <= req_len_w'(page_bytes));

  // Codes above 5 are reserved in device control, the register block
  // should never have handed one over for a request we accept
  a_codes_defined: assert property (@(posedge clk) disable iff (reset)
    start && !refuse |-> shadow.max_rd_code <= 3'd5 && shadow.max_payload_code <= 3'd5);

endmodule

//--- design/pcie_cfg_shadow_top.sv
`timescale 1ns/1ps

// Sideband sampler feeds the shadow registers, which in turn configure
// the read request splitter through the shadow interface
module pcie_cfg_shadow_top (
  input  logic                                 clk,
  input  logic                                 reset,
  // Hard IP configuration sideband
  input  logic [3:0]                           tl_cfg_add,
  input  logic [31:0]                          tl_cfg_ctl,
  // Status bus is not decoded by this design
  input  logic [52:0]                          tl_cfg_sts,
  // Client request
  input  logic                                 rd_req,
  input  logic [cfg_shadow_pkg::addr_w-1:0]    rd_addr,
  input  logic [cfg_shadow_pkg::req_len_w-1:0] rd_len,
  output logic                                 rd_ack,
  output logic                                 rd_err,
  // Header stream
  input  logic                                 hdr_ready,
  output logic                                 hdr_valid,
  output logic [cfg_shadow_pkg::addr_w-1:0]    hdr_addr,
  output logic [cfg_shadow_pkg::len_dw_w-1:0]  hdr_len_dw,
  output logic [15:0]                          hdr_req_id,
  output logic [cfg_shadow_pkg::tag_w-1:0]     hdr_tag,
  // Status
  output logic [15:0]                          my_id,
  output logic                                 my_id_valid
);
  import cfg_shadow_pkg::*;

  logic         cap_valid;
  logic [3:0]   cap_addr;
  logic [31:0]  cap_data;
  rd_hdr_t      hdr;

  cfg_shadow_if shadow_if ();

  cfg_sideband_sampler u_sampler (
    .clk        (clk),
    .reset      (reset),
    .tl_cfg_add (tl_cfg_add),
    .tl_cfg_ctl (tl_cfg_ctl),
    .cap_valid  (cap_valid),
    .cap_addr   (cap_addr),
    .cap_data   (cap_data)
  );

  cfg_shadow_regs u_regs (
    .clk         (clk),
    .reset       (reset),
    .cap_valid   (cap_valid),
    .cap_addr    (cap_addr),
    .cap_data    (cap_data),
    .shadow      (shadow_if.regs),
    .my_id       (my_id),
    .my_id_valid (my_id_valid)
  );

  rd_req_splitter u_splitter (
    .clk       (clk),
    .reset     (reset),
    .rd_req    (rd_req),
    .rd_addr   (rd_addr),
    .rd_len    (rd_len),
    .hdr_ready (hdr_ready),
    .shadow    (shadow_if.user),
    .rd_ack    (rd_ack),
    .rd_err    (rd_err),
    .hdr_valid (hdr_valid),
    .hdr       (hdr)
  );

  // Flatten the header for the link side
  assign hdr_addr   = hdr.addr;
  assign hdr_len_dw = hdr.len_dw;
  assign hdr_req_id = hdr.req_id;
  assign hdr_tag    = hdr.tag;

endmodule

//--- verification/tb_pcie_cfg_shadow.sv
`timescale 1ns/1ps

// A sideband model sweeps the sixteen tl_cfg addresses, a client issues reads,
// and assertions compare the header stream with a model of the chunk rule
module tb_pcie_cfg_shadow;
  import cfg_shadow_pkg::*;

  localparam int sweep_cycles = 128;

  logic        clk;
  logic        reset;
  logic [3:0]  tl_cfg_add;
  logic [31:0] tl_cfg_ctl;
  logic [52:0] tl_cfg_sts;
  logic        rd_req;
  logic [31:0] rd_addr;
  logic [12:0] rd_len;
  logic        rd_ack;
  logic        rd_err;
  logic        hdr_ready;
  logic        hdr_valid;
  logic [31:0] hdr_addr;
  logic [9:0]  hdr_len_dw;
  logic [15:0] hdr_req_id;
  logic [4:0]  hdr_tag;
  logic [15:0] my_id;
  logic        my_id_valid;

  // Sideband table, one word per address, and the position inside a window
  logic [31:0] cfg_table [0:15];
  logic [2:0]  win_cnt;
  logic [31:0] lfsr_state;

  // Expected headers, written when a request goes out and read as headers are accepted
  logic [31:0] exp_addr [0:1023];
  logic [9:0]  exp_len [0:1023];
  logic [31:0] wr_cnt = 32'd0;
  logic [31:0] rd_idx;
  logic [31:0] cur_addr;
  logic [9:0]  cur_len;
  logic [4:0]  exp_tag;
  logic [15:0] exp_id;
  logic        exp_err;
  logic        id_chk;
  logic [2:0]  cur_code;
  int          err_cnt;
  int          err_mark;
  int          tests_ok;
  int          tests_bad;

  pcie_cfg_shadow_top DUT (.*);

  always #5 clk = ~clk;

  // The Galois LFSR takes one step for every random bit taken
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  // Queues the headers a request should produce, then runs the four-phase handshake
  task automatic do_read(input logic [31:0] addr, input int len, input logic refused);
    logic [31:0] a;
    int          rem;
    int          chunk;
    a       = addr;
    rem     = refused ? 0 : len;
    exp_err = refused;
    // Smallest of what is left, the max read request and the rest of the 4 KB page
    while (rem > 0) begin
      chunk = rem;
      if (chunk > (int'(max_rd_bytes_base) << cur_code)) begin
        chunk = int'(max_rd_bytes_base) << cur_code;
      end
      if (chunk > int'(page_bytes) - int'(a % page_bytes)) begin
        chunk = int'(page_bytes) - int'(a % page_bytes);
      end
      exp_addr[wr_cnt[9:0]] = a;
      // A full 4 KB wraps to zero dwords
      exp_len[wr_cnt[9:0]]  = 10'(chunk / 4);
      wr_cnt = wr_cnt + 32'd1;
      a      = a + 32'(chunk);
      rem    = rem - chunk;
    end
    @(posedge clk);
    rd_req  <= 1'b1;
    rd_addr <= addr;
    rd_len  <= 13'(len);
    while (!rd_ack) begin
      @(posedge clk);
    end
    rd_req <= 1'b0;
    while (rd_ack) begin
      @(posedge clk);
    end
  endtask

  // The shadow picks up a table change within one sweep plus the capture delay
  task automatic set_cfg(input logic [3:0] a, input logic [31:0] v);
    cfg_table[a] = v;
    repeat (sweep_cycles + 16) @(posedge clk);
  endtask

  task automatic end_test(input string name);
    repeat (2) @(posedge clk);
    if (err_cnt == err_mark) begin
      tests_ok++;
      $display("%-28s ok", name);
    end else begin
      tests_bad++;
      $display("%-28s %0d errors", name, err_cnt - err_mark);
    end
    err_mark = err_cnt;
  endtask

  // Each address is held for eight cycles, data follows the table
  always @(posedge clk) begin
    win_cnt <= win_cnt + 3'd1;
    if (win_cnt == 3'd7) begin
      tl_cfg_add <= tl_cfg_add + 4'd1;
      tl_cfg_ctl <= cfg_table[tl_cfg_add + 4'd1];
    end else begin
      tl_cfg_ctl <= cfg_table[tl_cfg_add];
    end
  end

  // Random back-pressure on the header stream
  always @(posedge clk) begin : ready_gen
    logic [31:0] nxt;
    nxt = lfsr_step(lfsr_state);
    lfsr_state <= nxt;
    hdr_ready  <= nxt[0];
  end

  // Every accepted header retires one expected entry and moves the tag on
  always @(posedge clk) begin
    if (reset) begin
      rd_idx  <= '0;
      exp_tag <= '0;
    end else if (hdr_valid && hdr_ready) begin
      rd_idx  <= rd_idx + 32'd1;
      exp_tag <= exp_tag + 5'd1;
    end
  end

  assign cur_addr = exp_addr[rd_idx[9:0]];
  assign cur_len  = exp_len[rd_idx[9:0]];

  a_reset_idle: assert property (@(posedge clk)
    $fell(reset) |-> !my_id_valid && !hdr_valid && !rd_ack && !rd_err)
    else begin
      err_cnt++;
      $display("FAIL after reset my_id_valid %h hdr_valid %h rd_ack %h rd_err %h",
        $sampled(my_id_valid), $sampled(hdr_valid), $sampled(rd_ack), $sampled(rd_err));
    end

  a_my_id: assert property (@(posedge clk) disable iff (reset)
    id_chk |-> my_id_valid && my_id == exp_id)
    else begin
      err_cnt++;
      $display("FAIL my_id got %h expected %h", $sampled(my_id), $sampled(exp_id));
    end

  a_hdr_expected: assert property (@(posedge clk) disable iff (reset)
    hdr_valid |-> rd_idx != wr_cnt)
    else begin
      err_cnt++;
      $display("A header was presented when none was expected");
    end

  a_hdr_match: assert property (@(posedge clk) disable iff (reset)
    hdr_valid |-> hdr_addr == cur_addr && hdr_len_dw == cur_len &&
      hdr_req_id == exp_id && hdr_tag == exp_tag)
    else begin
      err_cnt++;
      $display("FAIL hdr_addr %h/%h hdr_len_dw %h/%h hdr_req_id %h/%h hdr_tag %h/%h",
        $sampled(hdr_addr), $sampled(cur_addr), $sampled(hdr_len_dw), $sampled(cur_len),
        $sampled(hdr_req_id), $sampled(exp_id), $sampled(hdr_tag), $sampled(exp_tag));
    end

  a_hdr_hold: assert property (@(posedge clk) disable iff (reset)
    hdr_valid && !hdr_ready |=> hdr_valid &&
      $stable({hdr_addr, hdr_len_dw, hdr_req_id, hdr_tag}))
    else begin
      err_cnt++;
      $display("A waiting header changed or was withdrawn before hdr_ready");
    end

  // Ack ends the request only once every expected header has gone out
  a_ack_end: assert property (@(posedge clk) disable iff (reset)
    $rose(rd_ack) |-> rd_err == exp_err && rd_idx == wr_cnt)
    else begin
      err_cnt++;
      $display("FAIL rd_err got %h expected %h with %0d headers outstanding",
        $sampled(rd_err), $sampled(exp_err), $sampled(wr_cnt) - $sampled(rd_idx));
    end

  // Twenty sweeps plus 64 cycles for every header queued so far
  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < 20 * sweep_cycles + 64 * int'(wr_cnt)) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, %0d of %0d headers accepted", cycles, rd_idx, wr_cnt);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    clk        = 1'b0;
    reset      = 1'b1;
    rd_req     = 1'b0;
    rd_addr    = '0;
    rd_len     = '0;
    hdr_ready  = 1'b0;
    tl_cfg_sts = '0;
    lfsr_state = 32'h36d7;
    win_cnt    = '0;
    err_cnt    = 0;
    err_mark   = 0;
    tests_ok   = 0;
    tests_bad  = 0;
    id_chk     = 1'b0;
    exp_err    = 1'b0;
    cur_code   = 3'd2;
    exp_id     = {8'h3a, 5'd7, 3'd0};
    // Unused addresses carry a word built from all four address bits
    for (int i = 0; i < 16; i++) begin
      cfg_table[i] = 32'h5ac3_0000 ^ (32'(i) * 32'h0101_1111);
    end
    cfg_table[cfg_addr_dev_ctl] = (32'd2 << 12) | (32'd1 << 5);
    cfg_table[cfg_addr_command] = 32'h0000_0006;
    cfg_table[cfg_addr_bus_dev] = (32'h3a << 5) | 32'd7;
    tl_cfg_add = '0;
    tl_cfg_ctl = cfg_table[0];
    repeat (8) @(posedge clk);
    reset <= 1'b0;

    // No sweep has completed yet
    do_read(32'h0001_0000, 256, 1'b1);
    end_test("reset and early request");

    // First sweep gives the ID, then a new bus and device get two sweeps to land
    while (!my_id_valid) begin
      @(posedge clk);
    end
    id_chk = 1'b1;
    repeat (sweep_cycles) @(posedge clk);
    id_chk = 1'b0;
    cfg_table[cfg_addr_bus_dev] = (32'hc5 << 5) | 32'd19;
    repeat (2 * sweep_cycles) @(posedge clk);
    exp_id = {8'hc5, 5'd19, 3'd0};
    id_chk = 1'b1;
    end_test("requester id capture");

    // Memory space enable stays on, bus master enable drops
    set_cfg(cfg_addr_command, 32'h0000_0002);
    do_read(32'h0001_0000, 512, 1'b1);
    do_read(32'h0001_2000, 4, 1'b1);
    set_cfg(cfg_addr_command, 32'h0000_0006);
    end_test("bus master disabled");

    for (int code = 0; code < 6; code++) begin
      cur_code = 3'(code);
      set_cfg(cfg_addr_dev_ctl, (32'(code) << 12) | (32'd1 << 5));
      do_read(32'h0002_0000 + 32'(code) * 32'h1000, 4096, 1'b0);
    end
    end_test("max read request sizes");

    // Code 5 allows 4 KB, so only the page limits the first header to 64 bytes
    do_read(32'h0003_0fc0, 1024, 1'b0);
    end_test("4 KB boundary split");

    // Many short headers so the tag wraps several times
    cur_code = 3'd1;
    set_cfg(cfg_addr_dev_ctl, (32'd1 << 12) | (32'd1 << 5));
    for (int i = 0; i < 20; i++) begin
      do_read(32'h0004_0000 + 32'(i) * 32'h1a4, 4 * ((i * 37) % 1024 + 1), 1'b0);
    end
    end_test("back-pressure and tags");

    $display("Tests ok %0d, failed %0d, assertion errors %0d", tests_ok, tests_bad, err_cnt);
    if (tests_bad == 0 && err_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- pcie_cfg_shadow.f
design/cfg_shadow_pkg.sv
design/cfg_shadow_if.sv
design/cfg_sideband_sampler.sv
design/cfg_shadow_regs.sv
design/rd_req_splitter.sv
design/pcie_cfg_shadow_top.sv
verification/tb_pcie_cfg_shadow.sv

//--- Makefile
TOP := tb_pcie_cfg_shadow
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f pcie_cfg_shadow.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f pcie_cfg_shadow.f \
	  --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG) || ! grep -q "TEST PASSED" $(LOG); then \
	  echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
